// File: aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
  input  logic clk,
  input  logic nrst,
  input  logic opValid,
  input  logic fromAlu,
  input  logic [dataflowPkg::aluOpWidth-1:0] aluOp,
  input  logic [dataflowPkg::dataWidth-1:0] busA,
  input  logic [dataflowPkg::dataWidth-1:0] busB,
  output logic [dataflowPkg::dataWidth-1:0] result,
  output logic carry,
  output logic zero
);

  import dataflowPkg::*;

  // Result with carry or borrow in the top bit
  logic [dataWidth:0] wideResult;

  // Flag update strobe
  logic flagLoad;

  // Combinational operation select
  always_comb
  begin
    wideResult = '0;
    case (aluOp)
      opAdd:
        wideResult = {1'b0, busA} + {1'b0, busB};
      // Top bit goes high on wrap, which is the borrow
      opSub:
        wideResult = {1'b0, busA} - {1'b0, busB};
      opAnd:
        wideResult = {1'b0, busA & busB};
      opOr:
        wideResult = {1'b0, busA | busB};
      opXor:
        wideResult = {1'b0, busA ^ busB};
      opPassA:
        wideResult = {1'b0, busA};
      opIncA:
        wideResult = {1'b0, busA} + 1'b1;
      // Old bit 7 lands in the carry position
      opShlA:
        wideResult = {busA, 1'b0};
      default:
        wideResult = '0;
    endcase
  end

  assign result = wideResult[dataWidth-1:0];

  // Flags follow only ALU writes
  assign flagLoad = opValid & fromAlu;

  // Carry and zero flops
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      carry <= 1'b0;
      zero <= 1'b0;
    end
    else if (flagLoad)
    begin
      carry <= wideResult[dataWidth];
      zero <= (result == '0);
    end
  end

endmodule

// File: busController.sv
`timescale 1ns/1ps

module busController (
  input  logic opValid,
  input  logic [dataflowPkg::regSelWidth-1:0] srcA,
  input  logic [dataflowPkg::regSelWidth-1:0] srcB,
  input  logic [dataflowPkg::regSelWidth-1:0] dst,
  input  logic fromAlu,
  input  logic [dataflowPkg::regCount-1:0][dataflowPkg::busPortCount-1:0]
               [dataflowPkg::dataWidth-1:0] regBusOutputs,
  output logic [dataflowPkg::regCount-1:0][dataflowPkg::srcPortCount-1:0] loadEnables,
  output logic [dataflowPkg::regCount-1:0][dataflowPkg::busPortCount-1:0] driveEnables,
  output logic [dataflowPkg::dataWidth-1:0] busA,
  output logic [dataflowPkg::dataWidth-1:0] busB
);

  import dataflowPkg::*;

  // Load enable decode
  // Exactly one register and one source when opValid is high
  always_comb
  begin
    loadEnables = '0;
    if (opValid)
    begin
      if (fromAlu)
        loadEnables[dst][srcAlu] = 1'b1;
      else
        loadEnables[dst][srcExt] = 1'b1;
    end
  end

  // Drive enable decode
  // srcA owns busA, srcB owns busB
  // Same register on both is fine, it just drives both ports
  always_comb
  begin
    driveEnables = '0;
    if (opValid)
    begin
      driveEnables[srcA][busAPort] = 1'b1;
      driveEnables[srcB][busBPort] = 1'b1;
    end
  end

  // Bus merge
  // Disabled drivers are zero, so OR yields the single active byte
  always_comb
  begin
    busA = '0;
    busB = '0;
    for (int i = 0; i < regCount; i++)
    begin
      busA = busA | regBusOutputs[i][busAPort];
      busB = busB | regBusOutputs[i][busBPort];
    end
  end

endmodule

// File: busRegister.sv
`timescale 1ns/1ps

module busRegister #(
  parameter logic [dataflowPkg::dataWidth-1:0] defaultValue = '0
) (
  input  logic clk,
  input  logic nrst,
  input  logic [dataflowPkg::srcPortCount-1:0][dataflowPkg::dataWidth-1:0] busInputs,
  input  logic [dataflowPkg::srcPortCount-1:0] loadEnable,
  input  logic [dataflowPkg::busPortCount-1:0] driveEnable,
  output logic [dataflowPkg::busPortCount-1:0][dataflowPkg::dataWidth-1:0] busOutputs,
  output logic [dataflowPkg::dataWidth-1:0] value
);

  import dataflowPkg::*;

  // Merged byte from all enabled input buses
  logic [dataWidth-1:0] loadByte;

  // Enabled inputs are ORed, stands in for a shared tri-state bus
  // Normally only one load enable is set at a time
  always_comb
  begin
    loadByte = '0;
    for (int i = 0; i < srcPortCount; i++)
    begin
      if (loadEnable[i])
        loadByte = loadByte | busInputs[i];
    end
  end

  // Stored byte, loads on any enabled input
  always_ff @(posedge clk or negedge nrst)
  begin
    if (!nrst)
    begin
      value <= defaultValue;
    end
    else if (|loadEnable)
    begin
      value <= loadByte;
    end
  end

  // Gated bus drivers
  // A disabled port outputs zero so the controller can OR all drivers
  always_comb
  begin
    for (int i = 0; i < busPortCount; i++)
    begin
      if (driveEnable[i])
        busOutputs[i] = value;
      else
        busOutputs[i] = '0;
    end
  end

endmodule

// File: dataflowPkg.sv
package dataflowPkg;

  // Datapath byte width
  localparam int dataWidth = 8;

  // General register file size and select width
  localparam int regCount = 4;
  localparam int regSelWidth = 2;

  // ALU operation code width
  localparam int aluOpWidth = 3;

  // Each register drives busA and busB
  localparam int busPortCount = 2;
  localparam int busAPort = 0;
  localparam int busBPort = 1;

  // Each register loads from the external byte or the ALU result
  localparam int srcPortCount = 2;
  localparam int srcExt = 0;
  localparam int srcAlu = 1;

  // ALU operation codes
  localparam logic [aluOpWidth-1:0] opAdd = 3'd0;
  localparam logic [aluOpWidth-1:0] opSub = 3'd1;
  localparam logic [aluOpWidth-1:0] opAnd = 3'd2;
  localparam logic [aluOpWidth-1:0] opOr = 3'd3;
  localparam logic [aluOpWidth-1:0] opXor = 3'd4;
  localparam logic [aluOpWidth-1:0] opPassA = 3'd5;
  localparam logic [aluOpWidth-1:0] opIncA = 3'd6;
  localparam logic [aluOpWidth-1:0] opShlA = 3'd7;

  // Reset bytes, index 0 is r0
  // r3 comes up all ones so the output port reads FF after reset
  localparam logic [regCount-1:0][dataWidth-1:0] regResetValue = {
    8'hFF,
    8'h00,
    8'h00,
    8'h00
  };

endpackage

// File: dataflowTop.f
dataflowPkg.sv
busRegister.sv
busController.sv
aluUnit.sv
dataflowTop.sv
dataflowTop_props.sv
tbDataflowTop.sv

// File: dataflowTop.sv
`timescale 1ns/1ps

module dataflowTop (
  input  logic clk,
  input  logic nrst,
  input  logic opValid,
  input  logic [dataflowPkg::regSelWidth-1:0] srcA,
  input  logic [dataflowPkg::regSelWidth-1:0] srcB,
  input  logic [dataflowPkg::regSelWidth-1:0] dst,
  input  logic fromAlu,
  input  logic [dataflowPkg::aluOpWidth-1:0] aluOp,
  input  logic [dataflowPkg::dataWidth-1:0] dataIn,
  output logic [dataflowPkg::dataWidth-1:0] dataOut,
  output logic carry,
  output logic zero
);

  import dataflowPkg::*;

  // Per-register bus driver bytes
  logic [regCount-1:0][busPortCount-1:0][dataWidth-1:0] regBusOutputs;
  // Per-register load and drive enables from the controller
  logic [regCount-1:0][srcPortCount-1:0] loadEnables;
  logic [regCount-1:0][busPortCount-1:0] driveEnables;
  // Register contents
  logic [regCount-1:0][dataWidth-1:0] regValues;
  // Operand buses and ALU output
  logic [dataWidth-1:0] busA;
  logic [dataWidth-1:0] busB;
  logic [dataWidth-1:0] result;
  // Shared source bytes seen by every register
  logic [srcPortCount-1:0][dataWidth-1:0] regInputs;

  assign regInputs[srcExt] = dataIn;
  assign regInputs[srcAlu] = result;

  // r0 to r3
  for (genvar i = 0; i < regCount; i++)
  begin : genReg
    busRegister #(
      .defaultValue(regResetValue[i])
    ) regInst (
      .clk(clk),
      .nrst(nrst),
      .busInputs(regInputs),
      .loadEnable(loadEnables[i]),
      .driveEnable(driveEnables[i]),
      .busOutputs(regBusOutputs[i]),
      .value(regValues[i])
    );
  end

  // Decode and bus merge
  busController ctrl (
    .opValid(opValid),
    .srcA(srcA),
    .srcB(srcB),
    .dst(dst),
    .fromAlu(fromAlu),
    .regBusOutputs(regBusOutputs),
    .loadEnables(loadEnables),
    .driveEnables(driveEnables),
    .busA(busA),
    .busB(busB)
  );

  // ALU and flags
  aluUnit alu (
    .clk(clk),
    .nrst(nrst),
    .opValid(opValid),
    .fromAlu(fromAlu),
    .aluOp(aluOp),
    .busA(busA),
    .busB(busB),
    .result(result),
    .carry(carry),
    .zero(zero)
  );

  // r3 is the output port
  assign dataOut = regValues[regCount-1];

endmodule

// File: dataflowTop_props.sv
`timescale 1ns/1ps

module dataflowTopProps (
  input logic clk,
  input logic nrst,
  input logic opValid,
  input logic fromAlu,
  input logic [dataflowPkg::dataWidth-1:0] dataOut,
  input logic carry,
  input logic zero
);

  // Count of failed assertions
  int assertFails = 0;

  // Reset state, sampled on the falling edge after the async clear has settled
  resetState: assert property (@(negedge clk)
    !nrst |-> (dataOut == '1 && !carry && !zero))
  else
  begin
    assertFails++;
    $error("dataOut or flags do not hold their reset values while nrst is low");
  end

  // Idle cycle leaves every visible output alone
  idleHold: assert property (@(posedge clk) disable iff (!nrst)
    !opValid |=> ($stable(dataOut) && $stable(carry) && $stable(zero)))
  else
  begin
    assertFails++;
    $error("dataOut or flags changed after a cycle with opValid low");
  end

  // External loads never touch the flags
  extLoadFlags: assert property (@(posedge clk) disable iff (!nrst)
    (opValid && !fromAlu) |=> ($stable(carry) && $stable(zero)))
  else
  begin
    assertFails++;
    $error("carry or zero changed after an operation with fromAlu low");
  end

endmodule

// File: runSim.sh
#!/bin/sh
# Build the datapath and its testbench, run it, then scan the log
verilator --binary --assert --top-module tbDataflowTop -f dataflowTop.f -o simDataflow \
  || { echo "Build failed"; exit 1; }
./obj_dir/simDataflow +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

// File: tbDataflowTop.sv
`timescale 1ns/1ps

module tbDataflowTop;

  import dataflowPkg::*;

  // Polling runs in 2 ns steps on odd ns, clock edges fall on multiples of 4 ns
  localparam int edgeTimeoutSteps = 10;

  // Operand pairs for the ALU sweep
  localparam logic [7:0] pairA [5] = '{8'h3C, 8'hFF, 8'h00, 8'h80, 8'h12};
  localparam logic [7:0] pairB [5] = '{8'hC5, 8'h01, 8'h00, 8'h80, 8'h34};

  logic clk = 1'b0;
  logic nrst;
  logic opValid;
  logic [regSelWidth-1:0] srcA;
  logic [regSelWidth-1:0] srcB;
  logic [regSelWidth-1:0] dst;
  logic fromAlu;
  logic [aluOpWidth-1:0] aluOp;
  logic [dataWidth-1:0] dataIn;
  logic [dataWidth-1:0] dataOut;
  logic carry;
  logic zero;

  // Shadow copy of r0 to r3 and the flags
  logic [dataWidth-1:0] modelRegs [regCount];
  logic modelCarry;
  logic modelZero;

  int cycleCount = 0;
  int checkCount = 0;
  int errorCount = 0;
  int timeoutCount = 0;

  // 8 ns clock
  always #4 clk = ~clk;

  always @(posedge clk)
    cycleCount++;

  dataflowTop uut (
    .clk(clk),
    .nrst(nrst),
    .opValid(opValid),
    .srcA(srcA),
    .srcB(srcB),
    .dst(dst),
    .fromAlu(fromAlu),
    .aluOp(aluOp),
    .dataIn(dataIn),
    .dataOut(dataOut),
    .carry(carry),
    .zero(zero)
  );

  bind dataflowTop dataflowTopProps propsInst (
    .clk(clk),
    .nrst(nrst),
    .opValid(opValid),
    .fromAlu(fromAlu),
    .dataOut(dataOut),
    .carry(carry),
    .zero(zero)
  );

  // Expected {carry, result} for one operation
  function automatic logic [8:0] expectAlu(input logic [2:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
    int sum;
    logic [7:0] res;
    logic cOut;
    sum = 0;
    res = 8'h00;
    cOut = 1'b0;
    case (op)
      opAdd:
      begin
        sum = int'(a) + int'(b);
        res = 8'(sum);
        cOut = (sum > 255);
      end
      // Borrow when the subtrahend is larger
      opSub:
      begin
        res = a - b;
        cOut = (a < b);
      end
      opAnd: res = a & b;
      opOr: res = a | b;
      opXor: res = a ^ b;
      opPassA: res = a;
      opIncA:
      begin
        res = a + 8'd1;
        cOut = (a == 8'hFF);
      end
      default:
      begin
        res = {a[6:0], 1'b0};
        cOut = a[7];
      end
    endcase
    return {cOut, res};
  endfunction

  // Wait for the next rising edge, return 1 ns after it
  // The first odd-ns poll after an edge is exactly 1 ns past it
  task automatic waitNextEdge();
    int target;
    int steps;
    target = cycleCount + 1;
    steps = 0;
    if (timeoutCount == 0)
    begin
      while (cycleCount < target && steps < edgeTimeoutSteps)
      begin
        #2;
        steps++;
      end
      if (cycleCount < target)
      begin
        timeoutCount++;
        $display("Timeout: no rising clock edge within %0d ns", edgeTimeoutSteps * 2);
      end
    end
  endtask

  task automatic checkValue(input string testName, input string what,
                            input logic [7:0] expected, input logic [7:0] actual);
    checkCount++;
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("MISMATCH %s %s expected %02h actual %02h", testName, what, expected, actual);
    end
  endtask

  task automatic checkOutputs(input string testName);
    checkValue(testName, "dataOut", modelRegs[3], dataOut);
    checkValue(testName, "carry", 8'(modelCarry), 8'(carry));
    checkValue(testName, "zero", 8'(modelZero), 8'(zero));
  endtask

  // Drive one micro-operation, step the model, check after the edge
  task automatic runOp(input string testName, input logic valid,
                       input logic [1:0] a, input logic [1:0] b, input logic [1:0] d,
                       input logic alu, input logic [2:0] op, input logic [7:0] din);
    logic [8:0] aluExpect;
    if (timeoutCount == 0)
    begin
      opValid = valid;
      srcA = a;
      srcB = b;
      dst = d;
      fromAlu = alu;
      aluOp = op;
      dataIn = din;
      if (valid && alu)
      begin
        aluExpect = expectAlu(op, modelRegs[a], modelRegs[b]);
        modelRegs[d] = aluExpect[7:0];
        modelCarry = aluExpect[8];
        modelZero = (aluExpect[7:0] == 8'h00);
      end
      else if (valid)
        modelRegs[d] = din;
      waitNextEdge();
      if (timeoutCount == 0)
        checkOutputs(testName);
    end
  endtask

  initial
  begin
    void'($urandom(32'h1119_cd73));
    nrst = 1'b0;
    opValid = 1'b0;
    srcA = '0;
    srcB = '0;
    dst = '0;
    fromAlu = 1'b0;
    aluOp = '0;
    dataIn = '0;
    modelRegs[0] = 8'h00;
    modelRegs[1] = 8'h00;
    modelRegs[2] = 8'h00;
    modelRegs[3] = 8'hFF;
    modelCarry = 1'b0;
    modelZero = 1'b0;

    // Start polling on the odd-ns grid, between clock edges
    #1;

    // Two clock cycles in reset
    waitNextEdge();
    waitNextEdge();
    nrst = 1'b1;
    if (timeoutCount == 0)
      checkOutputs("reset");

    // Every ALU code on r0 and r1, then on r1 against itself
    for (int p = 0; p < 5; p++)
    begin
      runOp("aluLoadA", 1'b1, 2'd0, 2'd0, 2'd0, 1'b0, opAdd, pairA[p]);
      runOp("aluLoadB", 1'b1, 2'd0, 2'd0, 2'd1, 1'b0, opAdd, pairB[p]);
      for (int op = 0; op < 8; op++)
      begin
        runOp("aluOps", 1'b1, 2'd0, 2'd1, 2'd3, 1'b1, 3'(op), 8'h00);
        runOp("aluSameReg", 1'b1, 2'd1, 2'd1, 2'd3, 1'b1, 3'(op), 8'h00);
      end
    end

    // External byte straight to the output port
    runOp("extLoad", 1'b1, 2'd2, 2'd1, 2'd3, 1'b0, opSub, 8'h5A);
    runOp("extLoad", 1'b1, 2'd0, 2'd3, 2'd3, 1'b0, opAdd, 8'hA5);

    // Idle cycles with noise on every other input
    for (int i = 0; i < 20; i++)
    begin
      runOp("holdIdle", 1'b0, 2'($urandom), 2'($urandom), 2'($urandom),
            1'($urandom), 3'($urandom), 8'($urandom));
    end
    // Valid external loads keep the flags
    for (int i = 0; i < 20; i++)
    begin
      runOp("holdFlags", 1'b1, 2'($urandom), 2'($urandom), 2'($urandom),
            1'b0, 3'($urandom), 8'($urandom));
    end

    // Mixed traffic, r3 favored as destination so dataOut keeps moving
    for (int i = 0; i < 300; i++)
    begin
      runOp("random", ($urandom % 4) != 0, 2'($urandom), 2'($urandom),
            (($urandom % 2) != 0) ? 2'd3 : 2'($urandom),
            1'($urandom), 3'($urandom), 8'($urandom));
    end

    $display("Checks: %0d  mismatches: %0d  timeouts: %0d  assertion failures: %0d",
             checkCount, errorCount, timeoutCount, uut.propsInst.assertFails);
    if (errorCount == 0 && timeoutCount == 0 && uut.propsInst.assertFails == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
